/* src/decode_stage.sv */
module decode_stage (
    input  tinker_pkg::instr_t   instr,
    input  tinker_pkg::addr_t    pc,
    input  tinker_pkg::word_t    rd_val,
    input  tinker_pkg::word_t    rs_val,
    input  tinker_pkg::word_t    rt_val,
    input  logic                 idex_mem_read,
    input  tinker_pkg::reg_idx_t idex_rd,
    output tinker_pkg::opcode_t  op,
    output tinker_pkg::reg_idx_t rd,
    output tinker_pkg::reg_idx_t rs,
    output tinker_pkg::reg_idx_t rt,
    output tinker_pkg::lit_t     lit,
    output tinker_pkg::ctrl_t    ctrl,
    output logic                 take_branch,
    output tinker_pkg::addr_t    branch_target,
    output logic                 load_stall
);
    import tinker_pkg::*;

    logic is_nop;     // squash slot, never writes or stalls
    logic reads_rd;   // rd is a source operand too

    // field split
    assign op  = opcode_t'(instr[31:27]);
    assign rd  = instr[26:22];
    assign rs  = instr[21:17];
    assign rt  = instr[16:12];
    assign lit = instr[11:0];

    assign is_nop = (instr == NOP_INSTR);

    always_comb begin
        ctrl = CTRL_NONE;
        if (!is_nop) begin
            case (op)
                op_add, op_addi, op_sub, op_subi,
                op_and, op_or, op_xor, op_not,
                op_shftr, op_shftri, op_shftl, op_shftli,
                op_mov_rr, op_mov_l: begin
                    ctrl.reg_write = 1'b1;
                end
                op_load: begin
                    ctrl.reg_write  = 1'b1;
                    ctrl.mem_read   = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                end
                op_store: ctrl.mem_write = 1'b1;
                op_halt:  ctrl.halt      = 1'b1;
                default:  ctrl = CTRL_NONE;  // branches and unknown codes
            endcase
        end
    end

    // branches resolve here, one slot lost on taken
    always_comb begin
        take_branch   = 1'b0;
        branch_target = pc + 32'd4;
        case (op)
            op_br: begin
                take_branch   = 1'b1;
                branch_target = rd_val[31:0];
            end
            op_brr_rd: begin
                take_branch   = 1'b1;
                branch_target = pc + rd_val[31:0];  // relative by register
            end
            op_brr_l: begin
                take_branch   = 1'b1;
                branch_target = pc + {{20{lit[11]}}, lit};
            end
            op_brnz: begin
                take_branch   = (rs_val != '0);
                branch_target = rd_val[31:0];
            end
            op_brgt: begin
                take_branch   = ($signed(rs_val) > $signed(rt_val));
                branch_target = rd_val[31:0];
            end
            default: take_branch = 1'b0;
        endcase
    end

    // load result not ready until MEM, hold the consumer one cycle
    always_comb begin
        reads_rd = op inside {op_addi, op_subi, op_shftri, op_shftli, op_mov_l,
                              op_store, op_br, op_brr_rd, op_brnz, op_brgt};
        load_stall = idex_mem_read && !is_nop &&
                     (idex_rd == rs || idex_rd == rt || (reads_rd && idex_rd == rd));
    end

endmodule

/* src/execute_stage.sv */
module execute_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  tinker_pkg::opcode_t  op,
    input  tinker_pkg::lit_t     lit,
    input  tinker_pkg::reg_idx_t rd,
    input  tinker_pkg::reg_idx_t rs,
    input  tinker_pkg::reg_idx_t rt,
    input  tinker_pkg::ctrl_t    ctrl,
    input  tinker_pkg::word_t    rd_val,
    input  tinker_pkg::word_t    rs_val,
    input  tinker_pkg::word_t    rt_val,
    input  logic                 hold,
    fwd_src_if.fwd_sink          fwd,
    data_port_if.master          dport,
    output tinker_pkg::ctrl_t    exmem_ctrl,
    output tinker_pkg::word_t    exmem_result,
    output tinker_pkg::reg_idx_t exmem_rd
);
    import tinker_pkg::*;

    fwd_sel_t sel_rd;
    fwd_sel_t sel_rs;
    fwd_sel_t sel_rt;
    word_t    opnd_rd;      // operands after forwarding
    word_t    opnd_rs;
    word_t    opnd_rt;
    word_t    lit_zx;
    word_t    lit_sx;
    word_t    alu_out;
    word_t    exmem_sdata;  // store data for MEM

    // newest producer wins
    function automatic fwd_sel_t pick_src(reg_idx_t idx);
        return (fwd.exmem_we && fwd.exmem_rd == idx) ? from_exmem :
               (fwd.wb_we && fwd.wb_rd == idx)       ? from_memwb : from_rf;
    endfunction

    function automatic word_t fwd_value(fwd_sel_t sel, word_t rf_val);
        case (sel)
            from_exmem: return fwd.exmem_value;
            from_memwb: return fwd.wb_value;
            default:    return rf_val;
        endcase
    endfunction

    always_comb begin
        sel_rd  = pick_src(rd);
        sel_rs  = pick_src(rs);
        sel_rt  = pick_src(rt);
        opnd_rd = fwd_value(sel_rd, rd_val);
        opnd_rs = fwd_value(sel_rs, rs_val);
        opnd_rt = fwd_value(sel_rt, rt_val);
    end

    assign lit_zx = {52'd0, lit};
    assign lit_sx = {{52{lit[11]}}, lit};  // address offsets

    always_comb begin
        case (op)
            op_add:    alu_out = opnd_rs + opnd_rt;
            op_addi:   alu_out = opnd_rd + lit_zx;
            op_sub:    alu_out = opnd_rs - opnd_rt;
            op_subi:   alu_out = opnd_rd - lit_zx;
            op_and:    alu_out = opnd_rs & opnd_rt;
            op_or:     alu_out = opnd_rs | opnd_rt;
            op_xor:    alu_out = opnd_rs ^ opnd_rt;
            op_not:    alu_out = ~opnd_rs;
            op_shftr:  alu_out = opnd_rs >> opnd_rt;
            op_shftri: alu_out = opnd_rd >> lit;
            op_shftl:  alu_out = opnd_rs << opnd_rt;
            op_shftli: alu_out = opnd_rd << lit;
            op_mov_rr: alu_out = opnd_rs;
            op_mov_l:  alu_out = {opnd_rd[63:12], lit};  // low 12 bits only
            op_load:   alu_out = opnd_rs + lit_sx;        // effective address
            op_store:  alu_out = opnd_rd + lit_sx;
            default:   alu_out = '0;
        endcase
    end

    // EX/MEM register, frozen after halt
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exmem_ctrl   <= CTRL_NONE;
            exmem_result <= '0;
            exmem_rd     <= '0;
            exmem_sdata  <= '0;
        end else if (!hold) begin
            exmem_ctrl   <= ctrl;
            exmem_result <= alu_out;
            exmem_rd     <= rd;
            exmem_sdata  <= opnd_rs;  // store writes rs
        end
    end

    // a load's alu result is its address, not forwardable
    assign fwd.exmem_we    = exmem_ctrl.reg_write && !exmem_ctrl.mem_to_reg;
    assign fwd.exmem_rd    = exmem_rd;
    assign fwd.exmem_value = exmem_result;

    assign dport.we    = exmem_ctrl.mem_write && !hold;  // no stores past halt
    assign dport.addr  = exmem_result[31:0];
    assign dport.wdata = exmem_sdata;

    // decode's load-use stall keeps a loaded register out of EX
    // until the data sits in MEM/WB
    assert property (@(posedge clk) disable iff (reset)
        exmem_ctrl.mem_read && ctrl != CTRL_NONE |-> rs != exmem_rd && rt != exmem_rd)
        else $error("load result used one cycle too early");

endmodule

/* src/register_file.sv */
module register_file (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 we,
    input  tinker_pkg::reg_idx_t waddr,
    input  tinker_pkg::word_t    wdata,
    input  tinker_pkg::reg_idx_t ra_rd,
    input  tinker_pkg::reg_idx_t ra_rs,
    input  tinker_pkg::reg_idx_t ra_rt,
    output tinker_pkg::word_t    rd_val,
    output tinker_pkg::word_t    rs_val,
    output tinker_pkg::word_t    rt_val
);
    import tinker_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;  // every register starts at zero
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // reads see the old value during a write
    assign rd_val = regs[ra_rd];
    assign rs_val = regs[ra_rs];
    assign rt_val = regs[ra_rt];

endmodule

/* src/tinker_core.sv */
module tinker_core #(
    parameter tinker_pkg::addr_t PC_RESET_ADDR = 32'h0000_2000,
    parameter int                MEM_BYTES     = 64 * 1024
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               load_valid,
    output logic               load_ready,
    input  tinker_pkg::addr_t  load_addr,
    input  tinker_pkg::instr_t load_data,
    output logic               store_valid,
    output tinker_pkg::addr_t  store_addr,
    output tinker_pkg::word_t  store_data,
    output logic               hlt
);
    import tinker_pkg::*;

    addr_t    pc;
    instr_t   fetch_instr;
    instr_t   ifid_instr;
    addr_t    ifid_pc;
    opcode_t  id_op;
    reg_idx_t id_rd, id_rs, id_rt;
    lit_t     id_lit;
    ctrl_t    id_ctrl;
    word_t    rf_rd_val, rf_rs_val, rf_rt_val;
    word_t    id_rd_val, id_rs_val, id_rt_val;  // after wb bypass
    logic     take_branch;
    addr_t    branch_target;
    logic     load_stall;
    opcode_t  idex_op;
    reg_idx_t idex_rd, idex_rs, idex_rt;
    lit_t     idex_lit;
    ctrl_t    idex_ctrl;
    word_t    idex_rd_val, idex_rs_val, idex_rt_val;
    ctrl_t    exmem_ctrl;
    word_t    exmem_result;
    reg_idx_t exmem_rd;
    ctrl_t    memwb_ctrl;
    reg_idx_t memwb_rd;
    word_t    memwb_result;
    word_t    memwb_mem;
    logic     hold;     // halt retired, everything freezes
    logic     load_we;
    logic     branch_src_busy;  // a branch source still sits in ID/EX or EX/MEM

    fwd_src_if   fwd ();
    data_port_if dport ();

    // register written this cycle reaches ID directly
    function automatic word_t wb_bypass(reg_idx_t idx, word_t rf_val);
        return (fwd.wb_we && fwd.wb_rd == idx) ? fwd.wb_value : rf_val;
    endfunction

    // a later stage writes one of three source registers
    function automatic logic writes_any(logic we, reg_idx_t dst, reg_idx_t a, reg_idx_t b,
                                        reg_idx_t c);
        return we && (dst == a || dst == b || dst == c);
    endfunction

    assign load_ready = reset;  // loader only while held in reset
    assign load_we    = load_valid && load_ready;

    unified_memory #(.MEM_BYTES(MEM_BYTES)) u_mem (
        .clk         (clk),
        .fetch_addr  (pc),
        .fetch_instr (fetch_instr),
        .dport       (dport),
        .load_we     (load_we),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

    // IF, stall and halt freeze the pc
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= PC_RESET_ADDR;
        end else if (!hold && !load_stall) begin
            pc <= take_branch ? branch_target : pc + 32'd4;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ifid_instr <= NOP_INSTR;
            ifid_pc    <= '0;
        end else if (!hold && !load_stall) begin
            ifid_instr <= take_branch ? NOP_INSTR : fetch_instr;  // squash wrong-path slot
            ifid_pc    <= pc;
        end
    end

    register_file u_rf (
        .clk    (clk),
        .reset  (reset),
        .we     (fwd.wb_we),
        .waddr  (fwd.wb_rd),
        .wdata  (fwd.wb_value),
        .ra_rd  (id_rd),
        .ra_rs  (id_rs),
        .ra_rt  (id_rt),
        .rd_val (rf_rd_val),
        .rs_val (rf_rs_val),
        .rt_val (rf_rt_val)
    );

    assign id_rd_val = wb_bypass(id_rd, rf_rd_val);
    assign id_rs_val = wb_bypass(id_rs, rf_rs_val);
    assign id_rt_val = wb_bypass(id_rt, rf_rt_val);

    decode_stage u_dec (
        .instr         (ifid_instr),
        .pc            (ifid_pc),
        .rd_val        (id_rd_val),
        .rs_val        (id_rs_val),
        .rt_val        (id_rt_val),
        .idex_mem_read (idex_ctrl.mem_read),
        .idex_rd       (idex_rd),
        .op            (id_op),
        .rd            (id_rd),
        .rs            (id_rs),
        .rt            (id_rt),
        .lit           (id_lit),
        .ctrl          (id_ctrl),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .load_stall    (load_stall)
    );

    // ID/EX, a stall turns this slot into a bubble
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idex_op     <= op_and;
            idex_rd     <= '0;
            idex_rs     <= '0;
            idex_rt     <= '0;
            idex_lit    <= '0;
            idex_ctrl   <= CTRL_NONE;
            idex_rd_val <= '0;
            idex_rs_val <= '0;
            idex_rt_val <= '0;
        end else if (!hold) begin
            idex_op     <= id_op;
            idex_rd     <= id_rd;
            idex_rs     <= id_rs;
            idex_rt     <= id_rt;
            idex_lit    <= id_lit;
            idex_ctrl   <= load_stall ? CTRL_NONE : id_ctrl;
            idex_rd_val <= id_rd_val;
            idex_rs_val <= id_rs_val;
            idex_rt_val <= id_rt_val;
        end
    end

    execute_stage u_ex (
        .clk          (clk),
        .reset        (reset),
        .op           (idex_op),
        .lit          (idex_lit),
        .rd           (idex_rd),
        .rs           (idex_rs),
        .rt           (idex_rt),
        .ctrl         (idex_ctrl),
        .rd_val       (idex_rd_val),
        .rs_val       (idex_rs_val),
        .rt_val       (idex_rt_val),
        .hold         (hold),
        .fwd          (fwd),
        .dport        (dport),
        .exmem_ctrl   (exmem_ctrl),
        .exmem_result (exmem_result),
        .exmem_rd     (exmem_rd)
    );

    // MEM/WB, load data captured from the same-cycle read
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            memwb_ctrl   <= CTRL_NONE;
            memwb_rd     <= '0;
            memwb_result <= '0;
            memwb_mem    <= '0;
        end else if (!hold) begin
            memwb_ctrl   <= exmem_ctrl;
            memwb_rd     <= exmem_rd;
            memwb_result <= exmem_result;
            memwb_mem    <= dport.rdata;
        end
    end

    assign fwd.wb_we    = memwb_ctrl.reg_write;
    assign fwd.wb_rd    = memwb_rd;
    assign fwd.wb_value = memwb_ctrl.mem_to_reg ? memwb_mem : memwb_result;

    // MEM/WB stays frozen on halt, so this holds until reset
    assign hold = memwb_ctrl.halt;
    assign hlt  = hold;

    assign store_valid = dport.we;
    assign store_addr  = dport.addr;
    assign store_data  = dport.wdata;

    // decode sees only the wb bypass, nothing from EX or MEM
    always_comb begin
        branch_src_busy = 1'b0;
        if (id_op inside {op_br, op_brr_rd, op_brnz, op_brgt}) begin
            branch_src_busy =
                writes_any(idex_ctrl.reg_write, idex_rd, id_rd, id_rs, id_rt) ||
                writes_any(exmem_ctrl.reg_write, exmem_rd, id_rd, id_rs, id_rt);
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        !load_stall && !hold |-> !branch_src_busy)
        else $error("branch resolved from a register still in flight");

endmodule

/* src/tinker_ifs.sv */
// result sources for operand forwarding into EX
interface fwd_src_if;
    import tinker_pkg::*;

    logic     exmem_we;       // EX/MEM holds an alu result for a register
    reg_idx_t exmem_rd;
    word_t    exmem_value;
    logic     wb_we;          // writeback this cycle
    reg_idx_t wb_rd;
    word_t    wb_value;

    modport fwd_src (
        output wb_we, wb_rd, wb_value,
        input  exmem_we, exmem_rd, exmem_value
    );

    modport fwd_sink (
        output exmem_we, exmem_rd, exmem_value,
        input  wb_we, wb_rd, wb_value
    );
endinterface

// MEM stage access to the unified memory, rdata same cycle
interface data_port_if;
    import tinker_pkg::*;

    logic  we;
    addr_t addr;
    word_t wdata;
    word_t rdata;

    modport master (output we, addr, wdata, input rdata);
    modport slave  (input we, addr, wdata, output rdata);
endinterface

/* src/tinker_pkg.sv */
package tinker_pkg;

    localparam int WORD_W   = 64;
    localparam int ADDR_W   = 32;
    localparam int INSTR_W  = 32;
    localparam int REG_W    = 5;
    localparam int LIT_W    = 12;
    localparam int NUM_REGS = 32;

    typedef logic [WORD_W-1:0]  word_t;     // register / data value
    typedef logic [ADDR_W-1:0]  addr_t;     // byte address, pc
    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [REG_W-1:0]   reg_idx_t;
    typedef logic [LIT_W-1:0]   lit_t;

    // integer subset of the tinker opcode map
    typedef enum logic [4:0] {
        op_and    = 5'h00,
        op_or     = 5'h01,
        op_xor    = 5'h02,
        op_not    = 5'h03,
        op_shftr  = 5'h04,
        op_shftri = 5'h05,
        op_shftl  = 5'h06,
        op_shftli = 5'h07,
        op_br     = 5'h08,
        op_brr_rd = 5'h09,
        op_brr_l  = 5'h0a,
        op_brnz   = 5'h0b,
        op_brgt   = 5'h0e,
        op_halt   = 5'h0f,
        op_load   = 5'h10,  // mov rd, (rs)(L)
        op_mov_rr = 5'h11,
        op_mov_l  = 5'h12,
        op_store  = 5'h13,  // mov (rd)(L), rs
        op_add    = 5'h18,
        op_addi   = 5'h19,
        op_sub    = 5'h1a,
        op_subi   = 5'h1b
    } opcode_t;

    typedef struct packed {
        logic reg_write;    // rd written in wb
        logic mem_read;     // load in mem
        logic mem_write;    // store in mem
        logic mem_to_reg;   // wb takes memory data
        logic halt;
    } ctrl_t;

    typedef enum logic [1:0] {
        from_rf    = 2'd0,
        from_exmem = 2'd1,
        from_memwb = 2'd2
    } fwd_sel_t;

    localparam instr_t NOP_INSTR = '0;  // and r0, r0, r0 encoding
    localparam ctrl_t  CTRL_NONE = '0;  // bubble, writes nothing

endpackage

/* src/unified_memory.sv */
module unified_memory #(
    parameter int MEM_BYTES = 64 * 1024
) (
    input  logic               clk,
    input  tinker_pkg::addr_t  fetch_addr,
    output tinker_pkg::instr_t fetch_instr,
    data_port_if.slave         dport,
    input  logic               load_we,
    input  tinker_pkg::addr_t  load_addr,
    input  tinker_pkg::instr_t load_data
);

    logic [7:0] mem [MEM_BYTES];  // little endian bytes

    always_ff @(posedge clk) begin
        if (dport.we) begin
            for (int i = 0; i < 8; i++) begin
                mem[dport.addr + i] <= dport.wdata[8*i +: 8];  // 64-bit store
            end
        end
        if (load_we) begin
            for (int i = 0; i < 4; i++) begin
                mem[load_addr + i] <= load_data[8*i +: 8];   // program word
            end
        end
    end

    // fetch port, 4 bytes
    assign fetch_instr = {mem[fetch_addr + 3], mem[fetch_addr + 2],
                          mem[fetch_addr + 1], mem[fetch_addr]};

    // data port, 8 bytes, no latency
    assign dport.rdata = {mem[dport.addr + 7], mem[dport.addr + 6],
                          mem[dport.addr + 5], mem[dport.addr + 4],
                          mem[dport.addr + 3], mem[dport.addr + 2],
                          mem[dport.addr + 1], mem[dport.addr]};

    // loader only runs while the core sits in reset, so MEM never stores then
    assert property (@(posedge clk) !(dport.we && load_we))
        else $error("store and program load in the same cycle");

endmodule

/* tb.f */
src/tinker_pkg.sv
src/tinker_ifs.sv
src/unified_memory.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/tinker_core.sv
verif/tb_clock.sv
verif/tinker_tb.sv

/* verif/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // power-on reset, released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* verif/tinker_tb.sv */
module tinker_tb;
    import tinker_pkg::*;

    localparam addr_t PC_BASE   = 32'h0000_2000;
    localparam int    MEM_BYTES = 64 * 1024;

    typedef struct packed {
        addr_t addr;
        word_t data;
    } store_t;

    logic   clk;
    logic   gen_reset;           // 16-cycle power-on reset
    logic   loading;             // loader keeps the core in reset
    logic   core_reset;
    logic   load_valid;
    logic   load_ready;
    addr_t  load_addr;
    instr_t load_data;
    logic   store_valid;
    addr_t  store_addr;
    word_t  store_data;
    logic   hlt;

    instr_t prog_q [$];          // program image, word i at PC_BASE + 4*i
    store_t exp_q [$];           // stores the ISA model expects, in order
    bit     store_was_valid = 1'b0;
    bit     head_valid = 1'b0;
    addr_t  head_addr = '0;
    word_t  head_data = '0;
    int     stores_seen = 0;
    int     value_errors = 0;
    int     other_errors = 0;
    int     timeouts = 0;

    assign core_reset = gen_reset || loading;

    tb_clock #(.PERIOD(100), .RESET_CYCLES(16)) u_clock (
        .clk   (clk),
        .reset (gen_reset)
    );

    tinker_core #(
        .PC_RESET_ADDR (PC_BASE),
        .MEM_BYTES     (MEM_BYTES)
    ) UUT (
        .clk         (clk),
        .reset       (core_reset),
        .load_valid  (load_valid),
        .load_ready  (load_ready),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .hlt         (hlt)
    );

    function automatic instr_t encode(opcode_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt,
                                      lit_t lit);
        return {op, rd, rs, rt, lit};
    endfunction

    task automatic emit(instr_t word);
        prog_q.push_back(word);
    endtask

    task automatic build_program();
        int b;
        // dependent alu chain, each result stored
        emit(encode(op_mov_l, 1, 0, 0, 12'h123));
        emit(encode(op_mov_l, 2, 0, 0, 12'h0f5));
        emit(encode(op_add, 3, 1, 2, 0));         // r2 one back, r1 two back
        emit(encode(op_store, 0, 3, 0, 12'h100));
        emit(encode(op_sub, 4, 3, 1, 0));
        emit(encode(op_store, 0, 4, 0, 12'h108));
        emit(encode(op_xor, 5, 4, 2, 0));
        emit(encode(op_and, 6, 5, 3, 0));
        emit(encode(op_or, 7, 6, 5, 0));          // r6 from EX/MEM, r5 from MEM/WB
        emit(encode(op_store, 0, 7, 0, 12'h110));
        emit(encode(op_not, 8, 7, 0, 0));
        emit(encode(op_store, 0, 8, 0, 12'h118));
        emit(encode(op_mov_l, 9, 0, 0, 12'h004));
        emit(encode(op_shftl, 10, 1, 9, 0));
        emit(encode(op_shftr, 11, 10, 9, 0));
        emit(encode(op_shftli, 10, 0, 0, 12'd8));
        emit(encode(op_shftri, 10, 0, 0, 12'd3));
        emit(encode(op_add, 12, 10, 11, 0));
        emit(encode(op_store, 0, 12, 0, 12'h120));
        emit(encode(op_mov_rr, 13, 12, 0, 0));
        emit(encode(op_addi, 13, 0, 0, 12'h7ff));
        emit(encode(op_subi, 13, 0, 0, 12'h010));
        emit(encode(op_store, 0, 13, 0, 12'h128));
        // store, load back, use at once
        emit(encode(op_store, 0, 8, 0, 12'h130));
        emit(encode(op_load, 14, 0, 0, 12'h130));
        emit(encode(op_add, 15, 14, 1, 0));       // load-use stall
        emit(encode(op_store, 0, 15, 0, 12'h138));
        emit(encode(op_load, 16, 0, 0, 12'h128));
        emit(encode(op_mov_rr, 17, 16, 0, 0));
        emit(encode(op_store, 0, 17, 0, 12'h140));
        // branch targets, built well ahead since decode reads them
        b = prog_q.size();
        emit(encode(op_mov_l, 20, 0, 0, 12'h002));
        emit(encode(op_shftli, 20, 0, 0, 12'd12)); // r20 = program base
        emit(encode(op_mov_rr, 22, 20, 0, 0));
        emit(encode(op_addi, 22, 0, 0, 4 * (b + 12)));
        emit(encode(op_mov_l, 23, 0, 0, 12'h008));
        emit(encode(op_mov_rr, 24, 20, 0, 0));
        emit(encode(op_addi, 24, 0, 0, 4 * (b + 21)));
        emit(encode(op_mov_rr, 25, 20, 0, 0));
        emit(encode(op_addi, 25, 0, 0, 4 * (b + 24)));
        emit(encode(op_mov_l, 26, 0, 0, 12'h005));
        emit(encode(op_br, 22, 0, 0, 0));
        emit(encode(op_store, 0, 1, 0, 12'h200));  // skipped
        emit(encode(op_store, 0, 2, 0, 12'h148));
        emit(encode(op_brr_rd, 23, 0, 0, 0));
        emit(encode(op_store, 0, 1, 0, 12'h208));  // skipped
        emit(encode(op_store, 0, 3, 0, 12'h150));
        emit(encode(op_brr_l, 0, 0, 0, 12'd8));
        emit(encode(op_store, 0, 1, 0, 12'h210));  // skipped
        emit(encode(op_store, 0, 4, 0, 12'h158));
        emit(encode(op_brnz, 24, 26, 0, 0));
        emit(encode(op_store, 0, 1, 0, 12'h218));  // skipped
        emit(encode(op_store, 0, 5, 0, 12'h160));
        emit(encode(op_brgt, 25, 0, 1, 0));        // 0 > r1 false, falls through
        emit(encode(op_store, 0, 6, 0, 12'h168));
        emit(encode(op_halt, 0, 0, 0, 0));
        repeat (4) emit(encode(op_store, 0, 1, 0, 12'h220));  // fetched behind halt
    endtask

    // ISA-level model, queues every store it performs
    task automatic run_model();
        word_t    regs [32];
        word_t    dmem [addr_t];
        addr_t    pc;
        addr_t    here;
        addr_t    ea;
        instr_t   ins;
        reg_idx_t rd, rs, rt;
        lit_t     lit;
        word_t    lit_sx;
        store_t   st;
        bit       done;
        int       steps;
        foreach (regs[i]) regs[i] = '0;
        pc    = PC_BASE;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 500) begin
            ins  = prog_q[(pc - PC_BASE) >> 2];
            {rd, rs, rt, lit} = ins[26:0];
            lit_sx = {{52{lit[11]}}, lit};
            here = pc;
            pc   = pc + 32'd4;
            case (opcode_t'(ins[31:27]))
                op_add:    regs[rd] = regs[rs] + regs[rt];
                op_addi:   regs[rd] = regs[rd] + {52'd0, lit};  // unsigned literal
                op_sub:    regs[rd] = regs[rs] - regs[rt];
                op_subi:   regs[rd] = regs[rd] - {52'd0, lit};
                op_and:    regs[rd] = regs[rs] & regs[rt];
                op_or:     regs[rd] = regs[rs] | regs[rt];
                op_xor:    regs[rd] = regs[rs] ^ regs[rt];
                op_not:    regs[rd] = ~regs[rs];
                op_shftr:  regs[rd] = regs[rs] >> regs[rt];
                op_shftri: regs[rd] = regs[rd] >> lit;
                op_shftl:  regs[rd] = regs[rs] << regs[rt];
                op_shftli: regs[rd] = regs[rd] << lit;
                op_br:     pc = regs[rd][31:0];
                op_brr_rd: pc = here + regs[rd][31:0];
                op_brr_l:  pc = here + lit_sx[31:0];
                op_brnz:   if (regs[rs] != '0) pc = regs[rd][31:0];
                op_brgt:   if ($signed(regs[rs]) > $signed(regs[rt])) pc = regs[rd][31:0];
                op_halt:   done = 1'b1;
                op_mov_rr: regs[rd] = regs[rs];
                op_mov_l:  regs[rd][11:0] = lit;
                op_load: begin
                    ea       = regs[rs][31:0] + lit_sx[31:0];
                    regs[rd] = dmem.exists(ea) ? dmem[ea] : '0;
                end
                op_store: begin
                    ea       = regs[rd][31:0] + lit_sx[31:0];
                    dmem[ea] = regs[rs];
                    st.addr  = ea;
                    st.data  = regs[rs];
                    exp_q.push_back(st);
                end
                default: ;
            endcase
            steps++;
        end
        if (!done) begin
            other_errors++;
            $display("reference model never reached halt");
        end
    endtask

    task automatic offer_word(addr_t addr, instr_t data);
        int gap;
        int waited;
        bit accepted;
        gap      = $urandom % 3;  // random idle cycles before the word
        waited   = 0;
        accepted = 1'b0;
        if (gap > 0) begin
            load_valid <= 1'b0;
            repeat (gap) @(posedge clk);
        end
        load_valid <= 1'b1;
        load_addr  <= addr;
        load_data  <= data;
        while (!accepted && waited < 50) begin
            @(posedge clk);
            waited++;
            accepted = load_valid && load_ready;  // values before this edge
        end
        if (!accepted) begin
            timeouts++;
            $display("loader timeout, word at %h was never accepted", addr);
        end
    endtask

    task automatic load_program();
        @(posedge clk);
        for (int i = 0; i < prog_q.size(); i++) begin
            offer_word(PC_BASE + 4 * i, prog_q[i]);
        end
        load_valid <= 1'b0;
        loading    <= 1'b0;  // core starts once power-on reset is gone too
    endtask

    // expected head for the store in this cycle, popped once it has gone by
    always @(negedge clk) begin
        if (store_was_valid) begin
            stores_seen++;
            if (exp_q.size() > 0) void'(exp_q.pop_front());
        end
        store_was_valid = store_valid && !core_reset;
        head_valid      = (exp_q.size() > 0);
        if (head_valid) begin
            head_addr = exp_q[0].addr;
            head_data = exp_q[0].data;
        end
    end

    // reset state
    assert property (@(posedge clk) (core_reset || $fell(core_reset)) |-> !hlt)
        else begin
            value_errors++;
            $display("FAILED time %0t: hlt got %b expected 0", $time, $sampled(hlt));
        end
    assert property (@(posedge clk) (core_reset || $fell(core_reset)) |-> !store_valid)
        else begin
            value_errors++;
            $display("FAILED time %0t: store_valid got %b expected 0", $time,
                     $sampled(store_valid));
        end
    assert property (@(posedge clk) load_ready == core_reset)
        else begin
            value_errors++;
            $display("FAILED time %0t: load_ready got %b expected %b", $time,
                     $sampled(load_ready), $sampled(core_reset));
        end
    assert property (@(posedge clk) load_valid |-> load_ready)
        else begin
            other_errors++;
            $display("a program word was offered while the loader was closed");
        end

    // store stream against the model, in order
    assert property (@(posedge clk) disable iff (core_reset) store_valid |-> head_valid)
        else begin
            other_errors++;
            $display("store at time %0t with nothing left in the expected queue", $time);
        end
    assert property (@(posedge clk) disable iff (core_reset)
        store_valid && head_valid |-> store_addr == head_addr)
        else begin
            value_errors++;
            $display("FAILED time %0t: store_addr got %h expected %h", $time,
                     $sampled(store_addr), $sampled(head_addr));
        end
    assert property (@(posedge clk) disable iff (core_reset)
        store_valid && head_valid |-> store_data == head_data)
        else begin
            value_errors++;
            $display("FAILED time %0t: store_data got %h expected %h", $time,
                     $sampled(store_data), $sampled(head_data));
        end

    // halt is sticky and ends all stores
    assert property (@(posedge clk) disable iff (core_reset) hlt |=> hlt)
        else begin
            value_errors++;
            $display("FAILED time %0t: hlt got %b expected 1", $time, $sampled(hlt));
        end
    assert property (@(posedge clk) disable iff (core_reset) hlt |-> !store_valid)
        else begin
            other_errors++;
            $display("store seen at time %0t after the core halted", $time);
        end

    initial begin
        int waited;
        load_valid = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        loading    = 1'b1;
        void'($urandom(66947));
        build_program();
        run_model();
        load_program();
        waited = 0;
        while (core_reset && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (core_reset) begin
            timeouts++;
            $display("reset never released");
        end
        waited = 0;
        while (!hlt && waited < 2000) begin  // program runs well under this
            @(negedge clk);
            waited++;
        end
        if (!hlt) begin
            timeouts++;
            $display("hlt never rose after the program started");
        end
        repeat (20) @(negedge clk);  // sticky-halt and no-store checks keep running
        @(posedge clk);
        assert (exp_q.size() == 0)
            else begin
                other_errors++;
                $display("%0d expected stores never appeared", exp_q.size());
            end
        $display("stores seen %0d, value errors %0d, other errors %0d, timeouts %0d",
                 stores_seen, value_errors, other_errors, timeouts);
        if (value_errors == 0 && other_errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
